/* mem_test_pkg.sv */
// Shared constants, pattern rule and controller states for the DDR memory test engine
// Import into any block that needs bus geometry or the test range
package mem_test_pkg;

	//--------------------------------------------------
	// Bus geometry
	//--------------------------------------------------
	localparam int BUS_WIDTH  = 64;						// AXI data width
	localparam int LANE_WIDTH = 16;						// Pattern lane
	localparam int LANES      = BUS_WIDTH / LANE_WIDTH;	// Lanes per beat
	localparam int ADDR_WIDTH = 32;						// Byte address
	localparam int BEAT_BYTES = BUS_WIDTH / 8;			// Bytes per beat

	//--------------------------------------------------
	// Burst and test range
	//--------------------------------------------------
	localparam int BURST_LEN   = 4;						// Beats per burst
	localparam int BURST_BYTES = BURST_LEN * BEAT_BYTES;	// 32 bytes
	localparam logic [ADDR_WIDTH-1:0] START_ADDR = '0;	// First byte of range
	localparam int NUM_BURSTS  = 16;
	// Start address of the final burst
	localparam logic [ADDR_WIDTH-1:0] LAST_ADDR =
		START_ADDR + ADDR_WIDTH'((NUM_BURSTS - 1) * BURST_BYTES);

	// Fixed AXI burst attributes, shared with the controller side
	localparam logic [7:0] AXI_LEN   = 8'(BURST_LEN - 1);	// AxLEN encoding
	localparam logic [2:0] AXI_SIZE  = 3'd3;				// 8 bytes per beat
	localparam logic [1:0] AXI_BURST = 2'b01;				// INCR

	// Test phase of the controller
	typedef enum logic [1:0]
	{
		IDLE  = 2'd0,
		WRITE = 2'd1,
		READ  = 2'd2,
		DONE  = 2'd3
	} ctrl_state_t;

	// Lane k of the beat at byte address A holds (A/2 + k), low 16 bits
	function automatic logic [BUS_WIDTH-1:0] pattern_beat(input logic [ADDR_WIDTH-1:0] adrs);
		logic [ADDR_WIDTH-1:0] half;	// Halfword index of lane 0
		logic [BUS_WIDTH-1:0]  beat;
		half = adrs >> 1;
		for (int k = 0; k < LANES; k++)
		begin
			beat[k*LANE_WIDTH +: LANE_WIDTH] = half[LANE_WIDTH-1:0] + LANE_WIDTH'(k);
		end
		return beat;
	endfunction

endpackage

/* adrs_generator.sv */
// Burst start address counter that walks the test range one burst at a time
// Clear at phase start, step once per completed burst, wraps after the final one
`timescale 1ns/100ps

module adrs_generator
(
	input  logic                              iCLK,
	input  logic                              iRST,
	input  logic                              i_clear,	// Reload range start
	input  logic                              i_step,	// Advance one burst
	output logic [mem_test_pkg::ADDR_WIDTH-1:0] o_adrs,
	output logic                              o_last	// Final burst of range
);

	import mem_test_pkg::*;

	//--------------------------------------------------
	// Address register
	//--------------------------------------------------
	logic [ADDR_WIDTH-1:0] r_adrs;		// Current burst start
	logic                  q_at_last;	// Sitting on the final burst

	assign q_at_last = (r_adrs == LAST_ADDR);

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			r_adrs <= START_ADDR;
		end
		else if (i_clear)
		begin
			r_adrs <= START_ADDR;				// New phase
		end
		else if (i_step)
		begin
			if (q_at_last)
			begin
				r_adrs <= START_ADDR;			// Wrap, range done
			end
			else
			begin
				r_adrs <= r_adrs + ADDR_WIDTH'(BURST_BYTES);
			end
		end
	end

	// Outputs come straight from the register
	assign o_adrs = r_adrs;
	assign o_last = q_at_last;		// Sequences finish on this burst

endmodule

/* write_sequence.sv */
// AXI4 write master that fills the test range with the pattern, one burst at a time
// Pulse i_start once; o_done pulses after the B response of the last burst
`timescale 1ns/100ps

module write_sequence
(
	input  logic                                iCLK,
	input  logic                                iRST,
	input  logic                                i_start,
	// Write address channel
	output logic [mem_test_pkg::ADDR_WIDTH-1:0] o_awaddr,
	output logic                                o_awvalid,
	input  logic                                i_awready,
	// Write data channel
	output logic [mem_test_pkg::BUS_WIDTH-1:0]  o_wdata,
	output logic                                o_wlast,
	output logic                                o_wvalid,
	input  logic                                i_wready,
	// Write response channel
	input  logic                                i_bvalid,
	output logic                                o_bready,
	output logic                                o_done
);

	import mem_test_pkg::*;

	logic                         r_awvalid, r_wvalid, r_bready, r_done;
	logic [$clog2(BURST_LEN)-1:0] r_beat;	// Beat within burst
	logic [ADDR_WIDTH-1:0]        r_wadrs;	// Byte address of current beat
	logic [ADDR_WIDTH-1:0]        q_adrs;	// Burst start from generator
	logic                         q_adrs_last;
	logic                         q_aw_fire, q_w_fire, q_b_fire, q_wlast;

	assign q_aw_fire = r_awvalid & i_awready;
	assign q_w_fire  = r_wvalid & i_wready;
	assign q_b_fire  = r_bready & i_bvalid;
	assign q_wlast   = (r_beat == $bits(r_beat)'(BURST_LEN - 1));

	//--------------------------------------------------
	// Burst address, stepped per B response
	//--------------------------------------------------
	adrs_generator u_adrs_gen
	(
		.iCLK    (iCLK),
		.iRST    (iRST),
		.i_clear (i_start),
		.i_step  (q_b_fire),
		.o_adrs  (q_adrs),
		.o_last  (q_adrs_last)
	);

	//--------------------------------------------------
	// Channel handshake control
	//--------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			r_awvalid <= 1'b0;
			r_wvalid  <= 1'b0;
			r_bready  <= 1'b0;
			r_beat    <= '0;
			r_done    <= 1'b0;
		end
		else
		begin
			r_done <= q_b_fire & q_adrs_last;	// Last burst answered
			// AW: raise on start or after a B that is not the last
			if (i_start | (q_b_fire & ~q_adrs_last))
				r_awvalid <= 1'b1;
			else if (q_aw_fire)
				r_awvalid <= 1'b0;
			// W stream follows the AW transfer
			if (q_aw_fire)
				r_wvalid <= 1'b1;
			else if (q_w_fire & q_wlast)
				r_wvalid <= 1'b0;
			if (q_aw_fire)
				r_bready <= 1'b1;				// Held until bvalid
			else if (q_b_fire)
				r_bready <= 1'b0;
			if (q_aw_fire)
				r_beat <= '0;
			else if (q_w_fire)
				r_beat <= r_beat + 1'b1;
		end
	end

	// Beat address, payload only
	always_ff @(posedge iCLK)
	begin
		if (q_aw_fire)
			r_wadrs <= q_adrs;
		else if (q_w_fire)
			r_wadrs <= r_wadrs + ADDR_WIDTH'(BEAT_BYTES);
	end

	assign o_awaddr  = q_adrs;					// Stable until B step
	assign o_awvalid = r_awvalid;
	assign o_wdata   = pattern_beat(r_wadrs);
	assign o_wlast   = q_wlast;
	assign o_wvalid  = r_wvalid;
	assign o_bready  = r_bready;
	assign o_done    = r_done;

endmodule

/* read_sequence.sv */
// AXI4 read master that reads the test range back and forwards each beat to the checker
// Pulse i_start once; o_done pulses with the registered final beat
`timescale 1ns/100ps

module read_sequence
(
	input  logic                                iCLK,
	input  logic                                iRST,
	input  logic                                i_start,
	// Read address channel
	output logic [mem_test_pkg::ADDR_WIDTH-1:0] o_araddr,
	output logic                                o_arvalid,
	input  logic                                i_arready,
	// Read data channel
	input  logic [mem_test_pkg::BUS_WIDTH-1:0]  i_rdata,
	input  logic                                i_rlast,
	input  logic                                i_rvalid,
	output logic                                o_rready,
	// Checker side
	output logic [mem_test_pkg::BUS_WIDTH-1:0]  o_data,
	output logic                                o_valid,
	output logic                                o_done
);

	import mem_test_pkg::*;

	logic                  r_arvalid, q_arvalid_cke;
	logic                  r_rready, q_rready_cke;
	logic                  r_valid, r_done;
	logic [BUS_WIDTH-1:0]  r_data;			// Registered read beat
	logic [ADDR_WIDTH-1:0] q_adrs;
	logic                  q_adrs_last;
	logic                  q_ar_fire, q_r_fire, q_rlast_fire;

	assign q_ar_fire    = r_arvalid & i_arready;
	assign q_r_fire     = r_rready & i_rvalid;
	assign q_rlast_fire = q_r_fire & i_rlast;

	//--------------------------------------------------
	// Toggle enables for arvalid and rready
	//--------------------------------------------------
	always_comb
	begin
		casez ({r_arvalid, i_start, q_rlast_fire, q_adrs_last, i_arready})
			5'b01???: q_arvalid_cke = 1'b1;	// Assert at phase start
			5'b0010?: q_arvalid_cke = 1'b1;	// Assert for next burst
			5'b1???1: q_arvalid_cke = 1'b1;	// Deassert on AR transfer
			default:  q_arvalid_cke = 1'b0;
		endcase

		casez ({r_rready, q_ar_fire, i_rvalid, i_rlast})
			4'b01??: q_rready_cke = 1'b1;	// Assert after AR
			4'b1?11: q_rready_cke = 1'b1;	// Deassert after rlast
			default: q_rready_cke = 1'b0;
		endcase
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			r_arvalid <= 1'b0;
			r_rready  <= 1'b0;
			r_valid   <= 1'b0;
			r_done    <= 1'b0;
		end
		else
		begin
			if (q_arvalid_cke)
				r_arvalid <= ~r_arvalid;
			if (q_rready_cke)
				r_rready <= ~r_rready;
			r_valid <= q_r_fire;					// Delayed valid to checker
			r_done  <= q_rlast_fire & q_adrs_last;	// Final beat of range
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (q_r_fire)
			r_data <= i_rdata;
	end

	//--------------------------------------------------
	// Burst address, stepped on each rlast transfer
	//--------------------------------------------------
	adrs_generator u_adrs_gen
	(
		.iCLK    (iCLK),
		.iRST    (iRST),
		.i_clear (i_start),
		.i_step  (q_rlast_fire),
		.o_adrs  (q_adrs),
		.o_last  (q_adrs_last)
	);

	assign o_araddr  = q_adrs;
	assign o_arvalid = r_arvalid;
	assign o_rready  = r_rready;
	assign o_data    = r_data;
	assign o_valid   = r_valid;
	assign o_done    = r_done;

endmodule

/* pattern_checker.sv */
// Compares read-back beats against the pattern rule and keeps the fail status
// Clear before a read phase; feed one valid beat per read transfer in address order
`timescale 1ns/100ps

module pattern_checker
(
	input  logic                               iCLK,
	input  logic                               iRST,
	input  logic                               i_clear,
	input  logic [mem_test_pkg::BUS_WIDTH-1:0] i_data,
	input  logic                               i_valid,
	output logic                               o_fail,
	output logic [7:0]                         o_err_count
);

	import mem_test_pkg::*;

	logic [ADDR_WIDTH-1:0] r_adrs;		// Address of expected beat
	logic [BUS_WIDTH-1:0]  q_expect;
	logic [LANES-1:0]      q_lane_err;	// One bit per 16-bit lane
	logic                  q_beat_err;
	logic                  r_fail;
	logic [7:0]            r_err_count;

	//--------------------------------------------------
	// Expected beat and lane compare
	//--------------------------------------------------
	assign q_expect = pattern_beat(r_adrs);

	for (genvar k = 0; k < LANES; k++)
	begin : g_lane
		assign q_lane_err[k] = i_data[k*LANE_WIDTH +: LANE_WIDTH]
			!= q_expect[k*LANE_WIDTH +: LANE_WIDTH];
	end

	assign q_beat_err = i_valid & (|q_lane_err);	// Any lane off

	always_ff @(posedge iCLK)
	begin
		if (iRST | i_clear)
		begin
			r_adrs      <= START_ADDR;
			r_fail      <= 1'b0;
			r_err_count <= '0;
		end
		else
		begin
			if (i_valid)
				r_adrs <= r_adrs + ADDR_WIDTH'(BEAT_BYTES);	// Next beat
			if (q_beat_err)
				r_fail <= 1'b1;								// Sticky
			if (q_beat_err && r_err_count != 8'hff)
				r_err_count <= r_err_count + 1'b1;			// Saturate at 255
		end
	end

	assign o_fail      = r_fail;
	assign o_err_count = r_err_count;

endmodule

/* mem_test_ctrl.sv */
// Phase controller for the memory test: write the range, read it back, then hold done
// A start pulse in IDLE or DONE begins a new run
`timescale 1ns/100ps

module mem_test_ctrl
(
	input  logic iCLK,
	input  logic iRST,
	input  logic i_start,
	input  logic i_wr_done,
	input  logic i_rd_done,
	output logic o_wr_start,
	output logic o_rd_start,
	output logic o_chk_clear,
	output logic o_busy,
	output logic o_done
);

	import mem_test_pkg::*;

	ctrl_state_t r_state;
	logic        r_wr_start, r_rd_start, r_chk_clear;	// One-cycle pulses

	//--------------------------------------------------
	// Phase FSM
	//--------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			r_state     <= IDLE;
			r_wr_start  <= 1'b0;
			r_rd_start  <= 1'b0;
			r_chk_clear <= 1'b0;
		end
		else
		begin
			r_wr_start  <= 1'b0;
			r_rd_start  <= 1'b0;
			r_chk_clear <= 1'b0;
			case (r_state)
				IDLE, DONE:
				begin
					if (i_start)
					begin
						r_state     <= WRITE;
						r_wr_start  <= 1'b1;
						r_chk_clear <= 1'b1;	// Drop old fail status at once
					end
				end
				WRITE:
				begin
					if (i_wr_done)
					begin
						r_state     <= READ;
						r_rd_start  <= 1'b1;
						r_chk_clear <= 1'b1;	// Checker address back to start
					end
				end
				READ:
				begin
					if (i_rd_done)
						r_state <= DONE;
				end
				default: r_state <= IDLE;
			endcase
		end
	end

	assign o_wr_start  = r_wr_start;
	assign o_rd_start  = r_rd_start;
	assign o_chk_clear = r_chk_clear;
	assign o_busy      = (r_state == WRITE) || (r_state == READ);
	assign o_done      = (r_state == DONE);		// Level until next start

endmodule

/* mem_test_top.sv */
// Top level of the DDR memory test engine, AXI4 master ports toward the DDR controller
// Pulse i_start, wait for o_done, then read o_fail and o_err_count
`timescale 1ns/100ps

module mem_test_top
(
	input  logic                                iCLK,
	input  logic                                iRST,
	// Control
	input  logic                                i_start,
	output logic                                o_busy,
	output logic                                o_done,
	output logic                                o_fail,
	output logic [7:0]                          o_err_count,
	// Write address
	output logic [mem_test_pkg::ADDR_WIDTH-1:0] o_awaddr,
	output logic                                o_awvalid,
	input  logic                                i_awready,
	// Write data
	output logic [mem_test_pkg::BUS_WIDTH-1:0]  o_wdata,
	output logic                                o_wlast,
	output logic                                o_wvalid,
	input  logic                                i_wready,
	// Write response
	input  logic                                i_bvalid,
	output logic                                o_bready,
	// Read address
	output logic [mem_test_pkg::ADDR_WIDTH-1:0] o_araddr,
	output logic                                o_arvalid,
	input  logic                                i_arready,
	// Read data
	input  logic [mem_test_pkg::BUS_WIDTH-1:0]  i_rdata,
	input  logic                                i_rlast,
	input  logic                                i_rvalid,
	output logic                                o_rready
);

	import mem_test_pkg::*;

	logic                 wr_start, wr_done, rd_start, rd_done, chk_clear;
	logic [BUS_WIDTH-1:0] chk_data;		// Read beat to checker
	logic                 chk_valid;

	//--------------------------------------------------
	// Phase control
	//--------------------------------------------------
	mem_test_ctrl u_ctrl
	(
		.iCLK(iCLK), .iRST(iRST), .i_start(i_start),
		.i_wr_done(wr_done), .i_rd_done(rd_done),
		.o_wr_start(wr_start), .o_rd_start(rd_start), .o_chk_clear(chk_clear),
		.o_busy(o_busy), .o_done(o_done)
	);

	write_sequence u_wr_seq
	(
		.iCLK(iCLK), .iRST(iRST), .i_start(wr_start),
		.o_awaddr(o_awaddr), .o_awvalid(o_awvalid), .i_awready(i_awready),
		.o_wdata(o_wdata), .o_wlast(o_wlast), .o_wvalid(o_wvalid), .i_wready(i_wready),
		.i_bvalid(i_bvalid), .o_bready(o_bready), .o_done(wr_done)
	);

	read_sequence u_rd_seq
	(
		.iCLK(iCLK), .iRST(iRST), .i_start(rd_start),
		.o_araddr(o_araddr), .o_arvalid(o_arvalid), .i_arready(i_arready),
		.i_rdata(i_rdata), .i_rlast(i_rlast), .i_rvalid(i_rvalid), .o_rready(o_rready),
		.o_data(chk_data), .o_valid(chk_valid), .o_done(rd_done)
	);

	pattern_checker u_checker
	(
		.iCLK(iCLK), .iRST(iRST), .i_clear(chk_clear),
		.i_data(chk_data), .i_valid(chk_valid),
		.o_fail(o_fail), .o_err_count(o_err_count)
	);

endmodule

/* tb_axi_mem_model.sv */
// Behavioral AXI4 slave memory for the testbench, one burst in flight per direction
// Ready and response stalls follow i_rnd; i_fault_arm flips one bit of one read beat once
`timescale 1ns/100ps

module tb_axi_mem_model
(
	input  logic                                iCLK,
	input  logic                                iRST,
	input  logic [4:0]                          i_rnd,			// Per-cycle go bits, all ones = no stall
	input  logic                                i_fill,			// Reload background data
	input  logic                                i_fault_arm,	// Arm fault, restart beat count
	input  logic [7:0]                          i_fault_beat,	// Read beat to corrupt
	input  logic [5:0]                          i_fault_bit,
	input  logic [mem_test_pkg::ADDR_WIDTH-1:0] i_awaddr,
	input  logic                                i_awvalid,
	output logic                                o_awready,
	input  logic [mem_test_pkg::BUS_WIDTH-1:0]  i_wdata,
	input  logic                                i_wlast,
	input  logic                                i_wvalid,
	output logic                                o_wready,
	output logic                                o_bvalid,
	input  logic                                i_bready,
	input  logic [mem_test_pkg::ADDR_WIDTH-1:0] i_araddr,
	input  logic                                i_arvalid,
	output logic                                o_arready,
	output logic [mem_test_pkg::BUS_WIDTH-1:0]  o_rdata,
	output logic                                o_rlast,
	output logic                                o_rvalid,
	input  logic                                i_rready,
	input  logic [5:0]                          i_peek_idx,		// Backdoor read for checks
	output logic [mem_test_pkg::BUS_WIDTH-1:0]  o_peek_data
);

	import mem_test_pkg::*;

	localparam int MEM_WORDS = NUM_BURSTS * BURST_LEN;

	logic [BUS_WIDTH-1:0]  mem [MEM_WORDS];
	logic [ADDR_WIDTH-1:0] w_adrs = '0;		// Next write beat
	logic [ADDR_WIDTH-1:0] r_adrs = '0;		// Next read beat
	logic                  b_pending = 1'b0;
	logic                  r_active = 1'b0;
	logic                  fault_armed = 1'b0;
	logic                  b_fired = 1'b0;
	logic                  r_fired = 1'b0;
	int                    r_cnt = 0;		// Beat within read burst
	int                    r_seen = 0;		// Read beats since arm
	logic                  awready = 1'b0;
	logic                  wready = 1'b0;
	logic                  arready = 1'b0;
	logic                  bvalid = 1'b0;
	logic                  rvalid = 1'b0;
	logic                  rlast = 1'b0;
	logic [BUS_WIDTH-1:0]  rdata = '0;

	// Background data, differs from the test pattern
	function automatic logic [BUS_WIDTH-1:0] fill_word(input int idx);
		return {16'hf00d ^ 16'(idx), ~16'(idx), 16'(idx * 7), 16'h5a5a ^ 16'(idx)};
	endfunction

	initial
	begin
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = fill_word(i);
	end

	//--------------------------------------------------
	// Transfers, taken on the rising edge
	//--------------------------------------------------
	always @(posedge iCLK)
	begin
		b_fired = bvalid & i_bready;
		r_fired = rvalid & i_rready;
		if (iRST)
		begin
			b_pending   = 1'b0;
			r_active    = 1'b0;
			fault_armed = 1'b0;
		end
		else
		begin
			if (i_fill)
			begin
				for (int i = 0; i < MEM_WORDS; i++)
					mem[i] = fill_word(i);
			end
			if (i_fault_arm)
			begin
				fault_armed = 1'b1;
				r_seen      = 0;
			end
			if (i_awvalid & awready)
				w_adrs = i_awaddr;
			if (i_wvalid & wready)
			begin
				mem[w_adrs[8:3]] = i_wdata;
				w_adrs += BEAT_BYTES;
				if (i_wlast)
					b_pending = 1'b1;			// Answer after last beat
			end
			if (b_fired)
				b_pending = 1'b0;
			if (i_arvalid & arready)
			begin
				r_adrs   = i_araddr;
				r_cnt    = 0;
				r_active = 1'b1;
			end
			if (r_fired)
			begin
				if (fault_armed && r_seen == int'(i_fault_beat))
					fault_armed = 1'b0;			// One shot spent
				r_seen++;
				r_cnt++;
				r_adrs += BEAT_BYTES;
				if (rlast)
					r_active = 1'b0;
			end
		end
	end

	//--------------------------------------------------
	// Outputs, updated on the falling edge
	//--------------------------------------------------
	always @(negedge iCLK)
	begin
		if (iRST)
		begin
			awready = 1'b0;
			wready  = 1'b0;
			arready = 1'b0;
			bvalid  = 1'b0;
			rvalid  = 1'b0;
			rlast   = 1'b0;
		end
		else
		begin
			awready = i_rnd[0];
			wready  = i_rnd[1];
			arready = i_rnd[3];
			if (!(bvalid && !b_fired))			// Hold a pending response
				bvalid = b_pending & i_rnd[2];
			if (!(rvalid && !r_fired))			// Hold a pending beat
			begin
				rvalid = r_active & i_rnd[4];
				rlast  = (r_cnt == BURST_LEN - 1);
				rdata  = mem[r_adrs[8:3]];
				if (fault_armed && r_seen == int'(i_fault_beat))
					rdata[i_fault_bit] = ~rdata[i_fault_bit];
			end
		end
	end

	assign o_awready   = awready;
	assign o_wready    = wready;
	assign o_arready   = arready;
	assign o_bvalid    = bvalid;
	assign o_rvalid    = rvalid;
	assign o_rlast     = rlast;
	assign o_rdata     = rdata;
	assign o_peek_data = mem[i_peek_idx];

endmodule

/* tb_mem_test.sv */
// Testbench for the DDR memory test engine against a behavioral AXI4 memory
// Runs clean, stalled, faulty and restarted tests and checks them against the pattern rule
`timescale 1ns/100ps

module tb_mem_test;

	import mem_test_pkg::*;

	localparam int SEED      = 8291;
	localparam int CLK_HALF  = 2;						// 4 ns period
	localparam int NUM_BEATS = NUM_BURSTS * BURST_LEN;	// Beats per phase
	localparam int NUM_RUNS  = 4;
	localparam int STALL_MAX = 20;						// Cycle bound per beat
	// Two phases per run plus the memory readout, then reset and margin
	localparam int WATCHDOG_NS =
		(NUM_RUNS * (NUM_BEATS * 2 * STALL_MAX + NUM_BEATS) + 64) * 2 * CLK_HALF;

	logic                  iCLK = 1'b0;
	logic                  iRST;
	logic                  start, busy, done, fail;
	logic [7:0]            err_cnt_dut;
	logic [ADDR_WIDTH-1:0] awaddr, araddr;
	logic                  awvalid, awready, wlast, wvalid, wready, bvalid, bready;
	logic                  arvalid, arready, rlast, rvalid, rready;
	logic [BUS_WIDTH-1:0]  wdata, rdata, peek_data;
	logic                  stall_en, fill, fault_arm;
	logic [4:0]            rnd;
	logic [7:0]            fault_beat;
	logic [5:0]            fault_bit, peek_idx;
	int                    errors = 0;
	int                    wr_beats = 0;
	int                    rd_beats = 0;
	int                    rd_bad = 0;		// Read beats off the pattern
	int                    aw_count = 0;
	int                    ar_count = 0;
	int                    runs_done = 0;
	int                    w_idx = 0;
	logic [ADDR_WIDTH-1:0] w_adrs, exp_adrs;
	logic [ADDR_WIDTH-1:0] rd_adrs;			// Expected address of next read beat
	// Previous cycle, for the hold checks
	logic                  p_awvalid = 1'b0, p_awready, p_wvalid = 1'b0, p_wready;
	logic                  p_arvalid = 1'b0, p_arready, p_wlast;
	logic [ADDR_WIDTH-1:0] p_awaddr, p_araddr;
	logic [BUS_WIDTH-1:0]  p_wdata;

	always #CLK_HALF iCLK = ~iCLK;

	mem_test_top DUT
	(
		.iCLK(iCLK), .iRST(iRST), .i_start(start),
		.o_busy(busy), .o_done(done), .o_fail(fail), .o_err_count(err_cnt_dut),
		.o_awaddr(awaddr), .o_awvalid(awvalid), .i_awready(awready),
		.o_wdata(wdata), .o_wlast(wlast), .o_wvalid(wvalid), .i_wready(wready),
		.i_bvalid(bvalid), .o_bready(bready),
		.o_araddr(araddr), .o_arvalid(arvalid), .i_arready(arready),
		.i_rdata(rdata), .i_rlast(rlast), .i_rvalid(rvalid), .o_rready(rready)
	);

	tb_axi_mem_model u_mem
	(
		.iCLK(iCLK), .iRST(iRST), .i_rnd(rnd), .i_fill(fill),
		.i_fault_arm(fault_arm), .i_fault_beat(fault_beat), .i_fault_bit(fault_bit),
		.i_awaddr(awaddr), .i_awvalid(awvalid), .o_awready(awready),
		.i_wdata(wdata), .i_wlast(wlast), .i_wvalid(wvalid), .o_wready(wready),
		.o_bvalid(bvalid), .i_bready(bready),
		.i_araddr(araddr), .i_arvalid(arvalid), .o_arready(arready),
		.o_rdata(rdata), .o_rlast(rlast), .o_rvalid(rvalid), .i_rready(rready),
		.i_peek_idx(peek_idx), .o_peek_data(peek_data)
	);

	//--------------------------------------------------
	// Reference model of the pattern rule
	//--------------------------------------------------
	function automatic logic [LANE_WIDTH-1:0] expect_lane(input logic [ADDR_WIDTH-1:0] adrs,
		input int k);
		return LANE_WIDTH'(adrs / 2 + k);		// Halfword index plus lane
	endfunction

	function automatic logic [BUS_WIDTH-1:0] expect_beat(input logic [ADDR_WIDTH-1:0] adrs);
		logic [BUS_WIDTH-1:0] beat;
		for (int k = 0; k < LANES; k++)
			beat[k*LANE_WIDTH +: LANE_WIDTH] = expect_lane(adrs, k);
		return beat;
	endfunction

	task automatic report_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		errors++;
		$display("error at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
	endtask

	task automatic report_fault(input string what);
		errors++;
		$display("At %0d ns: %s", $time, what);
	endtask

	task automatic print_counts();
		$display("Errors: %0d, write beats: %0d, read beats: %0d", errors, wr_beats, rd_beats);
	endtask

	// All random draws come from this one seeded process
	initial
	begin
		void'($urandom(SEED));
		fault_beat = 8'($urandom_range(NUM_BEATS - 1));
		fault_bit  = 6'($urandom_range(BUS_WIDTH - 1));
		rnd        = '1;
		forever
		begin
			@(posedge iCLK);
			rnd = stall_en ? 5'($urandom) : '1;		// Model reads it on the falling edge
		end
	end

	//--------------------------------------------------
	// Compare process, samples at the rising edge
	//--------------------------------------------------
	always @(posedge iCLK)
	begin
		if (!iRST)
		begin
			if (p_awvalid && !p_awready && (!awvalid || awaddr !== p_awaddr))
				report_fault("o_awvalid dropped or o_awaddr changed before its transfer");
			if (p_wvalid && !p_wready && (!wvalid || wdata !== p_wdata || wlast !== p_wlast))
				report_fault("o_wvalid dropped or write beat changed before its transfer");
			if (p_arvalid && !p_arready && (!arvalid || araddr !== p_araddr))
				report_fault("o_arvalid dropped or o_araddr changed before its transfer");
			if (awvalid && awready)
			begin
				exp_adrs = START_ADDR + ADDR_WIDTH'((aw_count % NUM_BURSTS) * BURST_BYTES);
				if (awaddr !== exp_adrs)
					report_value("o_awaddr", awaddr, exp_adrs);
				w_adrs = exp_adrs;
				w_idx  = 0;
				aw_count++;
			end
			if (wvalid && wready)
			begin
				if (wdata !== expect_beat(w_adrs))
					report_value("o_wdata", wdata, expect_beat(w_adrs));
				if (wlast !== (w_idx == BURST_LEN - 1))
					report_value("o_wlast", wlast, w_idx == BURST_LEN - 1);
				w_adrs += BEAT_BYTES;
				w_idx++;
				wr_beats++;
			end
			if (arvalid && arready)
			begin
				exp_adrs = START_ADDR + ADDR_WIDTH'((ar_count % NUM_BURSTS) * BURST_BYTES);
				if (araddr !== exp_adrs)
					report_value("o_araddr", araddr, exp_adrs);
				rd_adrs = exp_adrs;
				ar_count++;
			end
			if (rvalid && rready)
			begin
				if (rdata !== expect_beat(rd_adrs))
					rd_bad++;					// Checked per run against the injection
				rd_adrs += BEAT_BYTES;
				rd_beats++;
			end
		end
		p_awvalid = awvalid;
		p_awready = awready;
		p_awaddr  = awaddr;
		p_wvalid  = wvalid;
		p_wready  = wready;
		p_wdata   = wdata;
		p_wlast   = wlast;
		p_arvalid = arvalid;
		p_arready = arready;
		p_araddr  = araddr;
	end

	// One full test run, inputs driven on the falling edge
	task automatic run_test(input logic stalls, input logic inject, input logic restart);
		int bad_at_start;				// Corrupted read beats before this run
		bad_at_start = rd_bad;
		stall_en  = stalls;
		fill      = 1'b1;				// Fresh background so writes are proven again
		fault_arm = inject;
		@(negedge iCLK);
		fill      = 1'b0;
		fault_arm = 1'b0;
		start     = 1'b1;
		@(negedge iCLK);
		start = 1'b0;
		if (restart)
		begin
			@(negedge iCLK);			// Checker clear lands one cycle after start
			if (busy !== 1'b1 || done !== 1'b0 || fail !== 1'b0 || err_cnt_dut !== 8'd0)
				report_fault("restart did not clear done, fail and error count while busy");
		end
		while (done !== 1'b1)
			@(negedge iCLK);
		runs_done++;
		if (fail !== inject)
			report_value("o_fail", fail, inject);
		if (err_cnt_dut !== (inject ? 8'd1 : 8'd0))
			report_value("o_err_count", err_cnt_dut, inject ? 8'd1 : 8'd0);
		if (wr_beats != runs_done * NUM_BEATS || rd_beats != runs_done * NUM_BEATS)
			report_fault("wrong number of write or read beats in this run");
		if (rd_bad - bad_at_start != (inject ? 1 : 0))
			report_fault("wrong number of corrupted read beats in this run");
		// Memory readout through the backdoor port
		for (int i = 0; i < NUM_BEATS; i++)
		begin
			peek_idx = 6'(i);
			@(negedge iCLK);
			if (peek_data !== expect_beat(START_ADDR + ADDR_WIDTH'(i * BEAT_BYTES)))
				report_value("memory word", peek_data,
					expect_beat(START_ADDR + ADDR_WIDTH'(i * BEAT_BYTES)));
		end
	endtask

	//--------------------------------------------------
	// Main stimulus
	//--------------------------------------------------
	initial
	begin
		iRST      = 1'b1;
		start     = 1'b0;
		stall_en  = 1'b0;
		fill      = 1'b0;
		fault_arm = 1'b0;
		peek_idx  = '0;
		repeat (8) @(negedge iCLK);
		iRST = 1'b0;
		@(negedge iCLK);
		if (busy !== 1'b0 || done !== 1'b0 || fail !== 1'b0)
			report_fault("busy, done or fail not low after reset");
		if (awvalid !== 1'b0 || wvalid !== 1'b0 || arvalid !== 1'b0 || rready !== 1'b0
			|| bready !== 1'b0)
			report_fault("AXI valid or ready outputs not low after reset");
		if (err_cnt_dut !== 8'd0)
			report_value("o_err_count", err_cnt_dut, 8'd0);
		run_test(1'b0, 1'b0, 1'b0);		// Clean, no stalls
		run_test(1'b1, 1'b0, 1'b0);		// Random stalls
		run_test(1'b1, 1'b1, 1'b0);		// One corrupted read beat
		run_test(1'b1, 1'b0, 1'b1);		// Restart from DONE
		print_counts();
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the test runs did not finish", WATCHDOG_NS);
		print_counts();
		$display("Verification failed");
		$finish;
	end

endmodule

/* list.f */
mem_test_pkg.sv
adrs_generator.sv
write_sequence.sv
read_sequence.sv
pattern_checker.sv
mem_test_ctrl.sv
mem_test_top.sv
tb_axi_mem_model.sv
tb_mem_test.sv

/* Bender.yml */
package:
  name: mem_test

sources:
  - files:
      - mem_test_pkg.sv
      - adrs_generator.sv
      - write_sequence.sv
      - read_sequence.sv
      - pattern_checker.sv
      - mem_test_ctrl.sv
      - mem_test_top.sv
  - target: test
    files:
      - tb_axi_mem_model.sv
      - tb_mem_test.sv
